/* sources.f */
verilog/wb_bus_pkg.sv
verilog/periph_pkg.sv
verilog/wb_arbiter.sv
verilog/wb_addr_decoder.sv
verilog/block_ram.sv
verilog/simple_pic.sv
verilog/simple_gpio.sv
verilog/periph_system.sv
tests/periph_checker.sv
tests/tb_periph_system.sv

/* tests/tb_periph_system.sv */
`timescale 1ns/1ps

module tb_periph_system;

    localparam int CLK_PERIOD = 4;
    // Contention bound: the other master's access with its release cycle (3) plus 2 cycles
    localparam int MAX_LAT    = 5;
    localparam int N_RAM      = 60;
    localparam int N_ROUNDS   = 8;
    localparam int N_PIC      = 10;
    localparam int N_GPIO     = 8;
    localparam int N_ACC      = 2 * N_RAM + 4 * N_ROUNDS + 4 * N_PIC + 5 * N_GPIO;
    localparam int TIMEOUT    = N_ACC * (MAX_LAT + 8) * CLK_PERIOD + 2000;

    logic             clk;
    logic             rst_n;
    logic [1:0]       m_cyc;
    logic [1:0]       m_stb;
    logic [1:0]       m_we;
    logic [1:0][3:0]  m_sel;
    logic [1:0][31:0] m_adr;
    logic [1:0][31:0] m_wdat;
    logic [1:0][31:0] m_rdat;
    logic [1:0]       m_ack;
    logic [1:0]       m_err;
    logic [15:0]      irq;
    logic             int_o;
    logic [7:0]       gpio_in;
    logic [7:0]       gpio_out;
    logic [7:0]       gpio_oe;

    integer seed = 32'hf9c8;

    // Model state
    logic [31:0] mem_model [int];
    logic [15:0] pend_model;
    logic [15:0] en_model;
    logic [7:0]  out_model;
    logic [7:0]  dir_model;

    periph_system periph_system_inst (
        .wb_clk_i (clk), .rst_n_i (rst_n),
        .m0_cyc_i (m_cyc[0]), .m0_stb_i (m_stb[0]), .m0_we_i (m_we[0]),
        .m0_sel_i (m_sel[0]), .m0_adr_i (m_adr[0]), .m0_dat_i (m_wdat[0]),
        .m0_dat_o (m_rdat[0]), .m0_ack_o (m_ack[0]), .m0_err_o (m_err[0]),
        .m1_cyc_i (m_cyc[1]), .m1_stb_i (m_stb[1]), .m1_we_i (m_we[1]),
        .m1_sel_i (m_sel[1]), .m1_adr_i (m_adr[1]), .m1_dat_i (m_wdat[1]),
        .m1_dat_o (m_rdat[1]), .m1_ack_o (m_ack[1]), .m1_err_o (m_err[1]),
        .irq_i (irq), .int_o (int_o),
        .gpio_i (gpio_in), .gpio_o (gpio_out), .gpio_oe_o (gpio_oe)
    );

    periph_checker chk (
        .wb_clk_i (clk), .rst_n_i (rst_n),
        .m0_stb_i (m_stb[0]), .m0_ack_i (m_ack[0]), .m0_err_i (m_err[0]),
        .m1_stb_i (m_stb[1]), .m1_ack_i (m_ack[1]), .m1_err_i (m_err[1])
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(TIMEOUT);
        $display("Timeout: the tests did not finish within %0d ns", TIMEOUT);
        $display("Simulation FAILED");
        $finish;
    end

    // ------------------------------------------------------------
    // Wishbone classic access from master k
    // ------------------------------------------------------------
    task automatic bus_access(input int k, input logic we, input logic [3:0] sel,
                              input logic [31:0] adr, input logic [31:0] wdat,
                              output logic [31:0] rdat, output logic got_err);
        int lat;
        lat = 0;
        @(negedge clk);
        m_cyc[k]  = 1'b1;
        m_stb[k]  = 1'b1;
        m_we[k]   = we;
        m_sel[k]  = sel;
        m_adr[k]  = adr;
        m_wdat[k] = wdat;
        do begin
            @(negedge clk);
            lat++;
        end while (!(m_ack[k] || m_err[k]));
        if (lat > MAX_LAT) begin
            chk.report_failure($sformatf("master %0d waited %0d cycles", k, lat));
        end
        rdat    = m_rdat[k];
        got_err = m_err[k];
        m_cyc[k] = 1'b0;
        m_stb[k] = 1'b0;
    endtask

    function automatic logic [31:0] merge_bytes(input logic [31:0] old,
                                                input logic [31:0] wdat,
                                                input logic [3:0] sel);
        logic [31:0] res;
        res = old;
        for (int b = 0; b < 4; b++) begin
            if (sel[b]) begin
                res[8*b +: 8] = wdat[8*b +: 8];
            end
        end
        return res;
    endfunction

    task automatic ram_write(input int k, input int word, input logic [3:0] sel,
                             input logic [31:0] wdat);
        logic [31:0] rd;
        logic        e;
        bus_access(k, 1'b1, sel, {wb_bus_pkg::SLV_RAM, 28'(word << 2)}, wdat, rd, e);
        chk.check_value("ram write err", 32'd0, {31'd0, e});
        // A word's first write fills all lanes, so the merge base is irrelevant
        if (!mem_model.exists(word)) begin
            mem_model[word] = 32'd0;
        end
        mem_model[word] = merge_bytes(mem_model[word], wdat, sel);
    endtask

    // Full-word writes issued back to back, the master re-requests after each ack
    task automatic write_burst(input int k, input int word, input int n);
        for (int j = 0; j < n; j++) begin
            ram_write(k, word + j, 4'hf, $random(seed));
        end
    endtask

    // Random RAM and unmapped traffic from one master
    task automatic ram_traffic(input int k);
        int          word;
        int          kind;
        logic [31:0] rd;
        logic        e;
        logic [3:0]  field;
        for (int i = 0; i < N_RAM; i++) begin
            repeat ($unsigned($random(seed)) % 4) @(negedge clk);
            word = $unsigned($random(seed)) % 64;
            kind = $unsigned($random(seed)) % 8;
            if (kind == 0) begin
                field = 4'd3 + 4'($unsigned($random(seed)) % 13);
                bus_access(k, 1'b1, 4'hf, {field, 28'(word << 2)}, $random(seed), rd, e);
                chk.check_value("unmapped err", 32'd1, {31'd0, e});
            end else if (kind < 4 && mem_model.exists(word)) begin
                bus_access(k, 1'b0, 4'hf, {wb_bus_pkg::SLV_RAM, 28'(word << 2)}, 0, rd, e);
                chk.check_value("ram read", mem_model[word], rd);
            end else begin
                // First write of a word fills all lanes
                ram_write(k, word, mem_model.exists(word) ? 4'($random(seed)) : 4'hf,
                          $random(seed));
            end
        end
    endtask

    task automatic reg_access(input logic we, input logic [3:0] slv, input logic [1:0] ofs,
                              input logic [31:0] wdat, output logic [31:0] rdat);
        logic e;
        bus_access(0, we, 4'hf, {slv, 24'd0, ofs, 2'd0}, wdat, rdat, e);
        chk.check_value("register err", 32'd0, {31'd0, e});
    endtask

    initial begin
        logic [31:0] rd;
        logic [15:0] pulse;
        logic [15:0] clr;
        logic [31:0] val;
        m_cyc = '0;
        m_stb = '0;
        m_we = '0;
        m_sel = '0;
        m_adr = '0;
        m_wdat = '0;
        irq = '0;
        gpio_in = '0;
        rst_n = 1'b0;
        repeat (3) @(negedge clk);
        rst_n = 1'b1;
        chk.check_value("reset outputs", 32'd0,
                        {11'd0, gpio_oe, gpio_out, int_o, m_ack, m_err});
        pend_model = '0;
        en_model = '0;
        out_model = '0;
        dir_model = '0;

        // RAM and unmapped traffic from both masters at random times
        fork
            ram_traffic(0);
            ram_traffic(1);
        join

        // ------------------------------------------------------------
        // Both masters request on the same edge, then keep requesting
        // ------------------------------------------------------------
        chk.alt_en = 1'b1;
        for (int r = 0; r < N_ROUNDS; r++) begin
            fork
                write_burst(0, 64 + 2 * r, 2);
                write_burst(1, 96 + 2 * r, 2);
            join
        end
        chk.alt_en = 1'b0;

        // Interrupt controller
        for (int i = 0; i < N_PIC; i++) begin
            val = $random(seed);
            reg_access(1'b1, wb_bus_pkg::SLV_PIC, periph_pkg::PIC_REG_ENABLE, val, rd);
            en_model = val[15:0];
            pulse = $random(seed);
            @(negedge clk);
            irq = pulse;
            @(negedge clk);
            irq = '0;
            pend_model = pend_model | pulse;
            repeat (2) @(negedge clk);
            chk.check_value("int_o", {31'd0, |(pend_model & en_model)}, {31'd0, int_o});
            reg_access(1'b0, wb_bus_pkg::SLV_PIC, periph_pkg::PIC_REG_PENDING, 0, rd);
            chk.check_value("pic pending", {16'd0, pend_model}, rd);
            clr = $random(seed);
            reg_access(1'b1, wb_bus_pkg::SLV_PIC, periph_pkg::PIC_REG_PENDING, clr, rd);
            pend_model = pend_model & ~clr;
            reg_access(1'b0, wb_bus_pkg::SLV_PIC, periph_pkg::PIC_REG_PENDING, 0, rd);
            chk.check_value("pic clear", {16'd0, pend_model}, rd);
            repeat (2) @(negedge clk);
            chk.check_value("int_o clear", {31'd0, |(pend_model & en_model)},
                            {31'd0, int_o});
        end

        // GPIO controller
        for (int i = 0; i < N_GPIO; i++) begin
            val = $random(seed);
            reg_access(1'b1, wb_bus_pkg::SLV_GPIO, periph_pkg::GPIO_REG_OUT, val, rd);
            out_model = val[7:0];
            val = $random(seed);
            reg_access(1'b1, wb_bus_pkg::SLV_GPIO, periph_pkg::GPIO_REG_DIR, val, rd);
            dir_model = val[7:0];
            reg_access(1'b1, wb_bus_pkg::SLV_GPIO, periph_pkg::GPIO_REG_IN, $random(seed), rd);
            chk.check_value("gpio_o", {24'd0, out_model}, {24'd0, gpio_out});
            chk.check_value("gpio_oe_o", {24'd0, dir_model}, {24'd0, gpio_oe});
            gpio_in = $random(seed);
            repeat (3) @(negedge clk);
            reg_access(1'b0, wb_bus_pkg::SLV_GPIO, periph_pkg::GPIO_REG_IN, 0, rd);
            chk.check_value("gpio in", {24'd0, gpio_in}, rd);
            reg_access(1'b0, wb_bus_pkg::SLV_GPIO, periph_pkg::GPIO_REG_OUT, 0, rd);
            chk.check_value("gpio out reg", {24'd0, out_model}, rd);
        end

        repeat (4) @(negedge clk);
        $display("Checks done, errors: %0d", chk.errors);
        if (chk.errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

/* tests/periph_checker.sv */
`timescale 1ns/1ps

module periph_checker (
    input  logic wb_clk_i,
    input  logic rst_n_i,
    input  logic m0_stb_i,
    input  logic m0_ack_i,
    input  logic m0_err_i,
    input  logic m1_stb_i,
    input  logic m1_ack_i,
    input  logic m1_err_i
);

    int   errors = 0;
    // Set by the testbench while both masters request back to back
    logic alt_en = 1'b0;
    int   last_winner = -1;

    // Compare one value from the model with what the DUT returned
    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        if (exp !== act) begin
            errors++;
            $display("** Error [%s] expected 0x%08h actual 0x%08h at %0t",
                     name, exp, act, $time);
        end
    endtask

    task automatic report_failure(input string msg);
        errors++;
        $display("Error at %0t: %s", $time, msg);
    endtask

    // ------------------------------------------------------------
    // Bus protocol, sampled just after each rising edge
    // ------------------------------------------------------------
    always @(posedge wb_clk_i) begin
        #1;
        if (rst_n_i) begin
            if ((m0_ack_i || m0_err_i) && !m0_stb_i) begin
                report_failure("master 0 got a response without holding stb");
            end
            if ((m1_ack_i || m1_err_i) && !m1_stb_i) begin
                report_failure("master 1 got a response without holding stb");
            end
            if (m0_ack_i && m0_err_i) begin
                report_failure("master 0 saw ack and err together");
            end
            if (m1_ack_i && m1_err_i) begin
                report_failure("master 1 saw ack and err together");
            end
        end
    end

    // Round robin under constant contention
    always @(posedge wb_clk_i) begin
        #1;
        if (!alt_en) begin
            last_winner = -1;
        end else begin
            if (m0_ack_i || m0_err_i) begin
                if (last_winner == 0) begin
                    report_failure("master 0 won twice in a row under contention");
                end
                last_winner = 0;
            end
            if (m1_ack_i || m1_err_i) begin
                if (last_winner == 1) begin
                    report_failure("master 1 won twice in a row under contention");
                end
                last_winner = 1;
            end
        end
    end

endmodule

/* verilog/periph_system.sv */
`timescale 1ns/1ps

module periph_system #(
    parameter int DMEM_ADDR_WIDTH = 10,
    parameter int NUM_IRQ         = 16,
    parameter int GPIO_WIDTH      = 8
) (
    input  logic                             wb_clk_i,
    input  logic                             rst_n_i,
    // Master 0, data port
    input  logic                             m0_cyc_i,
    input  logic                             m0_stb_i,
    input  logic                             m0_we_i,
    input  logic [wb_bus_pkg::SEL_WIDTH-1:0] m0_sel_i,
    input  logic [wb_bus_pkg::ADR_WIDTH-1:0] m0_adr_i,
    input  logic [wb_bus_pkg::DAT_WIDTH-1:0] m0_dat_i,
    output logic [wb_bus_pkg::DAT_WIDTH-1:0] m0_dat_o,
    output logic                             m0_ack_o,
    output logic                             m0_err_o,
    // Master 1, DMA port
    input  logic                             m1_cyc_i,
    input  logic                             m1_stb_i,
    input  logic                             m1_we_i,
    input  logic [wb_bus_pkg::SEL_WIDTH-1:0] m1_sel_i,
    input  logic [wb_bus_pkg::ADR_WIDTH-1:0] m1_adr_i,
    input  logic [wb_bus_pkg::DAT_WIDTH-1:0] m1_dat_i,
    output logic [wb_bus_pkg::DAT_WIDTH-1:0] m1_dat_o,
    output logic                             m1_ack_o,
    output logic                             m1_err_o,
    // Interrupts and pins
    input  logic [NUM_IRQ-1:0]               irq_i,
    output logic                             int_o,
    input  logic [GPIO_WIDTH-1:0]            gpio_i,
    output logic [GPIO_WIDTH-1:0]            gpio_o,
    output logic [GPIO_WIDTH-1:0]            gpio_oe_o
);

    // Shared bus after the arbiter
    logic                             bus_cyc;
    logic                             bus_stb;
    logic                             bus_we;
    logic [wb_bus_pkg::SEL_WIDTH-1:0] bus_sel;
    logic [wb_bus_pkg::ADR_WIDTH-1:0] bus_adr;
    logic [wb_bus_pkg::DAT_WIDTH-1:0] bus_dat_w;
    logic [wb_bus_pkg::DAT_WIDTH-1:0] bus_dat_r;
    logic                             bus_ack;
    logic                             bus_err;

    // Per slave strobe and response
    logic                             ram_stb;
    logic                             pic_stb;
    logic                             gpio_stb;
    logic [wb_bus_pkg::DAT_WIDTH-1:0] ram_dat;
    logic [wb_bus_pkg::DAT_WIDTH-1:0] pic_dat;
    logic [wb_bus_pkg::DAT_WIDTH-1:0] gpio_dat;
    logic                             ram_ack;
    logic                             pic_ack;
    logic                             gpio_ack;

    // ------------------------------------------------------------
    // Arbiter and decoder
    // ------------------------------------------------------------
    wb_arbiter u_arbiter (
        .wb_clk_i  ( wb_clk_i  ), .rst_n_i   ( rst_n_i   ),
        .m0_cyc_i  ( m0_cyc_i  ), .m0_stb_i  ( m0_stb_i  ),
        .m0_we_i   ( m0_we_i   ), .m0_sel_i  ( m0_sel_i  ),
        .m0_adr_i  ( m0_adr_i  ), .m0_dat_i  ( m0_dat_i  ),
        .m0_dat_o  ( m0_dat_o  ), .m0_ack_o  ( m0_ack_o  ),
        .m0_err_o  ( m0_err_o  ),
        .m1_cyc_i  ( m1_cyc_i  ), .m1_stb_i  ( m1_stb_i  ),
        .m1_we_i   ( m1_we_i   ), .m1_sel_i  ( m1_sel_i  ),
        .m1_adr_i  ( m1_adr_i  ), .m1_dat_i  ( m1_dat_i  ),
        .m1_dat_o  ( m1_dat_o  ), .m1_ack_o  ( m1_ack_o  ),
        .m1_err_o  ( m1_err_o  ),
        .bus_cyc_o ( bus_cyc   ), .bus_stb_o ( bus_stb   ),
        .bus_we_o  ( bus_we    ), .bus_sel_o ( bus_sel   ),
        .bus_adr_o ( bus_adr   ), .bus_dat_o ( bus_dat_w ),
        .bus_dat_i ( bus_dat_r ), .bus_ack_i ( bus_ack   ),
        .bus_err_i ( bus_err   )
    );

    wb_addr_decoder u_decoder (
        .wb_clk_i   ( wb_clk_i  ), .rst_n_i    ( rst_n_i   ),
        .bus_cyc_i  ( bus_cyc   ), .bus_stb_i  ( bus_stb   ),
        .bus_adr_i  ( bus_adr   ), .bus_dat_i  ( bus_dat_w ),
        .ram_stb_o  ( ram_stb   ), .pic_stb_o  ( pic_stb   ),
        .gpio_stb_o ( gpio_stb  ),
        .ram_dat_i  ( ram_dat   ), .ram_ack_i  ( ram_ack   ),
        .pic_dat_i  ( pic_dat   ), .pic_ack_i  ( pic_ack   ),
        .gpio_dat_i ( gpio_dat  ), .gpio_ack_i ( gpio_ack  ),
        .bus_dat_o  ( bus_dat_r ), .bus_ack_o  ( bus_ack   ),
        .bus_err_o  ( bus_err   )
    );

    // ------------------------------------------------------------
    // Slaves
    // ------------------------------------------------------------
    block_ram #(
        .DMEM_ADDR_WIDTH ( DMEM_ADDR_WIDTH )
    ) u_dmem (
        .wb_clk_i ( wb_clk_i ), .rst_n_i ( rst_n_i   ),
        .stb_i    ( ram_stb  ), .we_i    ( bus_we    ),
        .sel_i    ( bus_sel  ), .adr_i   ( bus_adr   ),
        .dat_i    ( bus_dat_w ), .dat_o  ( ram_dat   ),
        .ack_o    ( ram_ack  )
    );

    simple_pic #(
        .NUM_IRQ ( NUM_IRQ )
    ) u_pic (
        .wb_clk_i ( wb_clk_i ), .rst_n_i ( rst_n_i   ),
        .stb_i    ( pic_stb  ), .we_i    ( bus_we    ),
        .adr_i    ( bus_adr  ), .dat_i   ( bus_dat_w ),
        .dat_o    ( pic_dat  ), .ack_o   ( pic_ack   ),
        .irq_i    ( irq_i    ), .int_o   ( int_o     )
    );

    simple_gpio #(
        .GPIO_WIDTH ( GPIO_WIDTH )
    ) u_gpio (
        .wb_clk_i ( wb_clk_i ), .rst_n_i   ( rst_n_i   ),
        .stb_i    ( gpio_stb ), .we_i      ( bus_we    ),
        .adr_i    ( bus_adr  ), .dat_i     ( bus_dat_w ),
        .dat_o    ( gpio_dat ), .ack_o     ( gpio_ack  ),
        .gpio_i   ( gpio_i   ), .gpio_o    ( gpio_o    ),
        .gpio_oe_o ( gpio_oe_o )
    );

endmodule

/* verilog/simple_gpio.sv */
`timescale 1ns/1ps

module simple_gpio #(
    parameter int GPIO_WIDTH = 8
) (
    input  logic                             wb_clk_i,
    input  logic                             rst_n_i,
    input  logic                             stb_i,
    input  logic                             we_i,
    input  logic [wb_bus_pkg::ADR_WIDTH-1:0] adr_i,
    input  logic [wb_bus_pkg::DAT_WIDTH-1:0] dat_i,
    output logic [wb_bus_pkg::DAT_WIDTH-1:0] dat_o,
    output logic                             ack_o,
    input  logic [GPIO_WIDTH-1:0]            gpio_i,
    output logic [GPIO_WIDTH-1:0]            gpio_o,
    output logic [GPIO_WIDTH-1:0]            gpio_oe_o
);

    logic [periph_pkg::REG_OFS_WIDTH-1:0] ofs;
    logic [GPIO_WIDTH-1:0] out_q;
    logic [GPIO_WIDTH-1:0] dir_q;
    logic [GPIO_WIDTH-1:0] in_meta;
    logic [GPIO_WIDTH-1:0] in_q;
    logic [wb_bus_pkg::DAT_WIDTH-1:0] rd_data;
    logic wr_en;

    assign ofs   = adr_i[periph_pkg::REG_OFS_WIDTH+1:2];
    assign wr_en = stb_i & we_i & ~ack_o;

    always_ff @(posedge wb_clk_i) begin
        if (!rst_n_i) begin
            out_q <= '0;
            dir_q <= '0;
        end else if (wr_en) begin
            if (ofs == periph_pkg::GPIO_REG_OUT) begin
                out_q <= dat_i[GPIO_WIDTH-1:0];
            end
            if (ofs == periph_pkg::GPIO_REG_DIR) begin
                dir_q <= dat_i[GPIO_WIDTH-1:0];
            end
        end
    end

    // Two flop synchronizer on the pins
    always_ff @(posedge wb_clk_i) begin
        in_meta <= gpio_i;
        in_q    <= in_meta;
    end

    assign gpio_o    = out_q;
    assign gpio_oe_o = dir_q;

    always_comb begin
        rd_data = '0;
        case (ofs)
            periph_pkg::GPIO_REG_OUT: rd_data[GPIO_WIDTH-1:0] = out_q;
            periph_pkg::GPIO_REG_DIR: rd_data[GPIO_WIDTH-1:0] = dir_q;
            periph_pkg::GPIO_REG_IN:  rd_data[GPIO_WIDTH-1:0] = in_q;
            default:                  rd_data = '0;
        endcase
    end

    always_ff @(posedge wb_clk_i) begin
        if (stb_i) begin
            dat_o <= rd_data;
        end
    end

    always_ff @(posedge wb_clk_i) begin
        if (!rst_n_i) begin
            ack_o <= 1'b0;
        end else begin
            ack_o <= stb_i & ~ack_o;
        end
    end

endmodule

/* verilog/simple_pic.sv */
`timescale 1ns/1ps

module simple_pic #(
    parameter int NUM_IRQ = 16
) (
    input  logic                             wb_clk_i,
    input  logic                             rst_n_i,
    input  logic                             stb_i,
    input  logic                             we_i,
    input  logic [wb_bus_pkg::ADR_WIDTH-1:0] adr_i,
    input  logic [wb_bus_pkg::DAT_WIDTH-1:0] dat_i,
    output logic [wb_bus_pkg::DAT_WIDTH-1:0] dat_o,
    output logic                             ack_o,
    input  logic [NUM_IRQ-1:0]               irq_i,
    output logic                             int_o
);

    logic [periph_pkg::REG_OFS_WIDTH-1:0] ofs;
    logic [NUM_IRQ-1:0] irq_q;
    logic [NUM_IRQ-1:0] edge_det;
    logic [NUM_IRQ-1:0] pending_q;
    logic [NUM_IRQ-1:0] enable_q;
    logic [NUM_IRQ-1:0] clr_mask;
    logic [wb_bus_pkg::DAT_WIDTH-1:0] rd_data;
    logic wr_en;

    assign ofs      = adr_i[periph_pkg::REG_OFS_WIDTH+1:2];
    assign wr_en    = stb_i & we_i & ~ack_o;
    assign edge_det = irq_i & ~irq_q;
    assign clr_mask = (wr_en && ofs == periph_pkg::PIC_REG_PENDING) ?
                      dat_i[NUM_IRQ-1:0] : '0;

    // ------------------------------------------------------------
    // Edge capture and pending bits
    // ------------------------------------------------------------
    always_ff @(posedge wb_clk_i) begin
        if (!rst_n_i) begin
            irq_q     <= '0;
            pending_q <= '0;
            enable_q  <= '0;
            int_o     <= 1'b0;
        end else begin
            irq_q <= irq_i;
            // New edge beats a clear in the same cycle
            pending_q <= (pending_q & ~clr_mask) | edge_det;
            if (wr_en && ofs == periph_pkg::PIC_REG_ENABLE) begin
                enable_q <= dat_i[NUM_IRQ-1:0];
            end
            int_o <= |(pending_q & enable_q);
        end
    end

    // ------------------------------------------------------------
    // Bus side
    // ------------------------------------------------------------
    always_comb begin
        rd_data = '0;
        case (ofs)
            periph_pkg::PIC_REG_PENDING: rd_data[NUM_IRQ-1:0] = pending_q;
            periph_pkg::PIC_REG_ENABLE:  rd_data[NUM_IRQ-1:0] = enable_q;
            default:                     rd_data = '0;
        endcase
    end

    always_ff @(posedge wb_clk_i) begin
        if (stb_i) begin
            dat_o <= rd_data;
        end
    end

    always_ff @(posedge wb_clk_i) begin
        if (!rst_n_i) begin
            ack_o <= 1'b0;
        end else begin
            ack_o <= stb_i & ~ack_o;
        end
    end

endmodule

/* verilog/block_ram.sv */
`timescale 1ns/1ps

module block_ram #(
    parameter int DMEM_ADDR_WIDTH = 10
) (
    input  logic                             wb_clk_i,
    input  logic                             rst_n_i,
    input  logic                             stb_i,
    input  logic                             we_i,
    input  logic [wb_bus_pkg::SEL_WIDTH-1:0] sel_i,
    input  logic [wb_bus_pkg::ADR_WIDTH-1:0] adr_i,
    input  logic [wb_bus_pkg::DAT_WIDTH-1:0] dat_i,
    output logic [wb_bus_pkg::DAT_WIDTH-1:0] dat_o,
    output logic                             ack_o
);

    logic [wb_bus_pkg::DAT_WIDTH-1:0] mem [0:2**DMEM_ADDR_WIDTH-1];
    logic [DMEM_ADDR_WIDTH-1:0] word_adr;
    logic wr_en;

    // Word address sits above the byte offset
    assign word_adr = adr_i[DMEM_ADDR_WIDTH+1:2];
    assign wr_en    = stb_i & we_i & ~ack_o;

    always_ff @(posedge wb_clk_i) begin
        if (wr_en) begin
            for (int b = 0; b < wb_bus_pkg::SEL_WIDTH; b++) begin
                if (sel_i[b]) begin
                    mem[word_adr][8*b +: 8] <= dat_i[8*b +: 8];
                end
            end
        end
        if (stb_i) begin
            dat_o <= mem[word_adr];
        end
    end

    // Single ack per strobe
    always_ff @(posedge wb_clk_i) begin
        if (!rst_n_i) begin
            ack_o <= 1'b0;
        end else begin
            ack_o <= stb_i & ~ack_o;
        end
    end

endmodule

/* verilog/wb_addr_decoder.sv */
`timescale 1ns/1ps

module wb_addr_decoder (
    input  logic                             wb_clk_i,
    input  logic                             rst_n_i,
    input  logic                             bus_cyc_i,
    input  logic                             bus_stb_i,
    input  logic [wb_bus_pkg::ADR_WIDTH-1:0] bus_adr_i,
    input  logic [wb_bus_pkg::DAT_WIDTH-1:0] bus_dat_i,
    output logic                             ram_stb_o,
    output logic                             pic_stb_o,
    output logic                             gpio_stb_o,
    input  logic [wb_bus_pkg::DAT_WIDTH-1:0] ram_dat_i,
    input  logic                             ram_ack_i,
    input  logic [wb_bus_pkg::DAT_WIDTH-1:0] pic_dat_i,
    input  logic                             pic_ack_i,
    input  logic [wb_bus_pkg::DAT_WIDTH-1:0] gpio_dat_i,
    input  logic                             gpio_ack_i,
    output logic [wb_bus_pkg::DAT_WIDTH-1:0] bus_dat_o,
    output logic                             bus_ack_o,
    output logic                             bus_err_o
);

    wb_bus_pkg::slave_sel_t slv_sel;
    logic access;
    logic err_q;

    assign access = bus_cyc_i & bus_stb_i;

    always_comb begin
        case (bus_adr_i[wb_bus_pkg::SLV_FIELD_HI:wb_bus_pkg::SLV_FIELD_LO])
            wb_bus_pkg::SLV_RAM:  slv_sel = wb_bus_pkg::SEL_RAM;
            wb_bus_pkg::SLV_PIC:  slv_sel = wb_bus_pkg::SEL_PIC;
            wb_bus_pkg::SLV_GPIO: slv_sel = wb_bus_pkg::SEL_GPIO;
            default:              slv_sel = wb_bus_pkg::SEL_NONE;
        endcase
    end

    assign ram_stb_o  = access & (slv_sel == wb_bus_pkg::SEL_RAM);
    assign pic_stb_o  = access & (slv_sel == wb_bus_pkg::SEL_PIC);
    assign gpio_stb_o = access & (slv_sel == wb_bus_pkg::SEL_GPIO);

    // Unmapped access, one err pulse per strobe
    always_ff @(posedge wb_clk_i) begin
        if (!rst_n_i) begin
            err_q <= 1'b0;
        end else begin
            err_q <= access & (slv_sel == wb_bus_pkg::SEL_NONE) & ~err_q;
        end
    end

    // ------------------------------------------------------------
    // Response mux
    // ------------------------------------------------------------
    always_comb begin
        bus_dat_o = '0;
        bus_ack_o = 1'b0;
        case (slv_sel)
            wb_bus_pkg::SEL_RAM: begin
                bus_dat_o = ram_dat_i;
                bus_ack_o = ram_ack_i;
            end
            wb_bus_pkg::SEL_PIC: begin
                bus_dat_o = pic_dat_i;
                bus_ack_o = pic_ack_i;
            end
            wb_bus_pkg::SEL_GPIO: begin
                bus_dat_o = gpio_dat_i;
                bus_ack_o = gpio_ack_i;
            end
            default: begin
                bus_dat_o = '0;
                bus_ack_o = 1'b0;
            end
        endcase
    end

    assign bus_err_o = err_q;

    a_ack_err_excl: assert property (
        @(posedge wb_clk_i) disable iff (!rst_n_i)
        !(bus_ack_o && bus_err_o)
    ) else $error("Slave ack and bus error raised in the same cycle");

    // A waiting access keeps address and write data steady
    a_req_stable: assert property (
        @(posedge wb_clk_i) disable iff (!rst_n_i)
        (access && !bus_ack_o && !bus_err_o) ##1 access
            |-> ($stable(bus_adr_i) && $stable(bus_dat_i))
    ) else $error("Address or write data changed before the access ended");

endmodule

/* verilog/wb_arbiter.sv */
`timescale 1ns/1ps

module wb_arbiter (
    input  logic                             wb_clk_i,
    input  logic                             rst_n_i,
    // Master 0
    input  logic                             m0_cyc_i,
    input  logic                             m0_stb_i,
    input  logic                             m0_we_i,
    input  logic [wb_bus_pkg::SEL_WIDTH-1:0] m0_sel_i,
    input  logic [wb_bus_pkg::ADR_WIDTH-1:0] m0_adr_i,
    input  logic [wb_bus_pkg::DAT_WIDTH-1:0] m0_dat_i,
    output logic [wb_bus_pkg::DAT_WIDTH-1:0] m0_dat_o,
    output logic                             m0_ack_o,
    output logic                             m0_err_o,
    // Master 1
    input  logic                             m1_cyc_i,
    input  logic                             m1_stb_i,
    input  logic                             m1_we_i,
    input  logic [wb_bus_pkg::SEL_WIDTH-1:0] m1_sel_i,
    input  logic [wb_bus_pkg::ADR_WIDTH-1:0] m1_adr_i,
    input  logic [wb_bus_pkg::DAT_WIDTH-1:0] m1_dat_i,
    output logic [wb_bus_pkg::DAT_WIDTH-1:0] m1_dat_o,
    output logic                             m1_ack_o,
    output logic                             m1_err_o,
    // Shared bus
    output logic                             bus_cyc_o,
    output logic                             bus_stb_o,
    output logic                             bus_we_o,
    output logic [wb_bus_pkg::SEL_WIDTH-1:0] bus_sel_o,
    output logic [wb_bus_pkg::ADR_WIDTH-1:0] bus_adr_o,
    output logic [wb_bus_pkg::DAT_WIDTH-1:0] bus_dat_o,
    input  logic [wb_bus_pkg::DAT_WIDTH-1:0] bus_dat_i,
    input  logic                             bus_ack_i,
    input  logic                             bus_err_i
);

    logic [wb_bus_pkg::NUM_MASTERS-1:0] req;
    logic gnt_valid;
    // Index of the granted master, kept after release as the last winner
    logic gnt_idx;
    logic gnt_cyc;
    logic next_idx;
    logic sel_m0;
    logic sel_m1;

    assign req     = {m1_cyc_i, m0_cyc_i};
    assign gnt_cyc = gnt_idx ? m1_cyc_i : m0_cyc_i;

    // Round robin, the loser of the last grant goes first
    assign next_idx = (&req) ? ~gnt_idx : req[1];

    always_ff @(posedge wb_clk_i) begin
        if (!rst_n_i) begin
            gnt_valid <= 1'b0;
            gnt_idx   <= 1'b1;
        end else if (gnt_valid) begin
            if (!gnt_cyc) begin
                gnt_valid <= 1'b0;
            end
        end else if (|req) begin
            gnt_valid <= 1'b1;
            gnt_idx   <= next_idx;
        end
    end

    // ------------------------------------------------------------
    // Request and response muxes
    // ------------------------------------------------------------
    assign sel_m0 = gnt_valid & ~gnt_idx;
    assign sel_m1 = gnt_valid & gnt_idx;

    assign bus_cyc_o = gnt_valid & gnt_cyc;
    assign bus_stb_o = gnt_valid & (gnt_idx ? m1_stb_i : m0_stb_i);
    assign bus_we_o  = gnt_idx ? m1_we_i  : m0_we_i;
    assign bus_sel_o = gnt_idx ? m1_sel_i : m0_sel_i;
    assign bus_adr_o = gnt_idx ? m1_adr_i : m0_adr_i;
    assign bus_dat_o = gnt_idx ? m1_dat_i : m0_dat_i;

    assign m0_dat_o = sel_m0 ? bus_dat_i : '0;
    assign m0_ack_o = sel_m0 & bus_ack_i;
    assign m0_err_o = sel_m0 & bus_err_i;
    assign m1_dat_o = sel_m1 ? bus_dat_i : '0;
    assign m1_ack_o = sel_m1 & bus_ack_i;
    assign m1_err_o = sel_m1 & bus_err_i;

    // Owner keeps the bus for its whole cycle
    a_grant_held: assert property (
        @(posedge wb_clk_i) disable iff (!rst_n_i)
        (gnt_valid && gnt_cyc) |=> (gnt_valid && gnt_idx == $past(gnt_idx))
    ) else $error("Grant moved while the owning master held cyc");

endmodule

/* verilog/periph_pkg.sv */
package periph_pkg;

    // Word-offset bits decoded by the controllers
    localparam int REG_OFS_WIDTH = 2;

    // ------------------------------------------------------------
    // Interrupt controller registers
    // ------------------------------------------------------------
    localparam logic [REG_OFS_WIDTH-1:0] PIC_REG_PENDING = 2'd0;
    localparam logic [REG_OFS_WIDTH-1:0] PIC_REG_ENABLE  = 2'd1;

    // ------------------------------------------------------------
    // GPIO controller registers
    // ------------------------------------------------------------
    localparam logic [REG_OFS_WIDTH-1:0] GPIO_REG_OUT = 2'd0;
    localparam logic [REG_OFS_WIDTH-1:0] GPIO_REG_DIR = 2'd1;
    // Read only, writes are dropped
    localparam logic [REG_OFS_WIDTH-1:0] GPIO_REG_IN  = 2'd2;

endpackage

/* verilog/wb_bus_pkg.sv */
package wb_bus_pkg;

    // ------------------------------------------------------------
    // Bus widths
    // ------------------------------------------------------------
    localparam int ADR_WIDTH   = 32;
    localparam int DAT_WIDTH   = 32;
    localparam int SEL_WIDTH   = 4;
    localparam int NUM_MASTERS = 2;

    // ------------------------------------------------------------
    // Slave address map
    // ------------------------------------------------------------
    // Top nibble of the address picks the slave
    localparam int SLV_FIELD_HI = 31;
    localparam int SLV_FIELD_LO = 28;

    localparam logic [3:0] SLV_RAM  = 4'd0;
    localparam logic [3:0] SLV_PIC  = 4'd1;
    localparam logic [3:0] SLV_GPIO = 4'd2;

    // Decoded slave, NONE ends in a bus error
    typedef enum logic [1:0] {
        SEL_RAM  = 2'd0,
        SEL_PIC  = 2'd1,
        SEL_GPIO = 2'd2,
        SEL_NONE = 2'd3
    } slave_sel_t;

endpackage
